// ==== src/dallanma_config.svh ====
`ifndef DALLANMA_CONFIG_SVH
`define DALLANMA_CONFIG_SVH

`default_nettype none

// ----------------------------------------
// Program sayaci
// ----------------------------------------
`define DAL_PS_W 32             // Program sayaci genisligi.
`define DAL_BUYRUK_BAYT 4       // Sirali buyruk adimi, bayt.

// ----------------------------------------
// Ongorucu tablosu
// ----------------------------------------
`define DAL_BHT_IDX_W 6                     // Tablo indeks genisligi.
`define DAL_BHT_DERINLIK (1 << `DAL_BHT_IDX_W) // Tablo giris sayisi.
`define DAL_BHT_IDX_LSB 2                   // Indeks PS bit 2'den baslar.

`default_nettype wire

`endif

// ==== src/dal_turu_pkg.sv ====
`default_nettype none

package dal_turu_pkg;

    // Coz asamasindan gelen dallanma turu.
    typedef enum logic [2:0] {
        DAL_BEQ  = 3'd0, // Esitse atla.
        DAL_BNE  = 3'd1, // Esit degilse atla.
        DAL_BLT  = 3'd2, // Isaretli kucukse atla.
        DAL_BGE  = 3'd3, // Isaretli buyuk esitse atla.
        DAL_BLTU = 3'd4, // Isaretsiz kucukse atla.
        DAL_BGEU = 3'd5  // Isaretsiz buyuk esitse atla.
    } dal_turu_e;        // 6 ve 7 gecersiz.

    // Alti turden biri mi.
    function automatic logic dal_turu_gecerli_mi(input dal_turu_e tur);
        return (tur <= DAL_BGEU);
    endfunction

    // Karsilastirma isaretli mi yapilacak.
    function automatic logic imzali_tur_mu(input dal_turu_e tur);
        return (tur == DAL_BLT) || (tur == DAL_BGE);
    endfunction

endpackage

`default_nettype wire

// ==== src/ongoru_pkg.sv ====
`default_nettype none

package ongoru_pkg;

    // ----------------------------------------
    // 2 bitlik doyumlu sayac durumlari
    // ----------------------------------------
    typedef enum logic [1:0] {
        GUCLU_ATLAMAZ = 2'd0, // Alt doyum noktasi.
        ZAYIF_ATLAMAZ = 2'd1, // Sifirlama sonrasi durum.
        ZAYIF_ATLAR   = 2'd2, // Atlar ongorusu, zayif.
        GUCLU_ATLAR   = 2'd3  // Ust doyum noktasi.
    } sayac_e;

    // Ust yari atlar ongorur.
    function automatic logic sayac_atlar_mi(input sayac_e sayac);
        return (sayac == ZAYIF_ATLAR) || (sayac == GUCLU_ATLAR);
    endfunction

    // Sifirlama degeri, ust seviyeden parametre olarak gecer.
    localparam sayac_e SAYAC_SIFIR = ZAYIF_ATLAMAZ;

endpackage

`default_nettype wire

// ==== src/karsilastirici.sv ====
`timescale 1ns/1ps
`include "dallanma_config.svh"
`default_nettype none

module karsilastirici
    import dal_turu_pkg::*;
(
    input  wire [`DAL_PS_W-1:0] kaynak1_i,  // Birinci kaynak yazmac.
    input  wire [`DAL_PS_W-1:0] kaynak2_i,  // Ikinci kaynak yazmac.
    input  wire dal_turu_e      dal_turu_i, // Isaret secimi icin tur.
    output logic                esit_mi_o,  // kaynak1 == kaynak2.
    output logic                buyuk_mu_o  // kaynak1 > kaynak2.
);

    // ----------------------------------------
    // Bayrak uretimi
    // ----------------------------------------
    logic imzali;        // BLT ve BGE icin isaretli.
    logic buyuk_imzali;  // Isaretli buyukluk.
    logic buyuk_imzasiz; // Isaretsiz buyukluk.

    assign imzali = imzali_tur_mu(dal_turu_i);

    // Esitlik isaretten bagimsiz.
    assign esit_mi_o = (kaynak1_i == kaynak2_i);

    assign buyuk_imzali  = ($signed(kaynak1_i) > $signed(kaynak2_i)); // 80000000 en kucuk.
    assign buyuk_imzasiz = (kaynak1_i > kaynak2_i);                   // 80000000 buyuk.

    // BEQ/BNE icin buyuk_mu kullanilmaz, isaretsiz kalir.
    assign buyuk_mu_o = imzali ? buyuk_imzali : buyuk_imzasiz;

endmodule

`default_nettype wire

// ==== src/dallanma_birimi.sv ====
`timescale 1ns/1ps
`include "dallanma_config.svh"
`default_nettype none

module dallanma_birimi
    import dal_turu_pkg::*;
(
    input  wire                 clk_i,               // Saat.
    input  wire                 rst_i,               // Senkron sifirlama.
    input  wire                 blok_aktif_i,        // Dallanma buyrugu var.
    input  wire [`DAL_PS_W-1:0] dallanma_ps_i,       // Dallanmanin PS'i.
    input  wire [`DAL_PS_W-1:0] anlik_i,             // Isaret genisletilmis anlik.
    input  wire dal_turu_e      dal_buy_turu_i,      // Coz asamasindan tur.
    input  wire                 dallanma_ongorusu_i, // 1 ise atlar denmisti.
    input  wire                 esit_mi_i,           // Karsilastirici bayragi.
    input  wire                 buyuk_mu_i,          // Karsilastirici bayragi.
    output logic                guncelle_gecerli_o,  // Ongorucu guncelleme darbesi.
    output logic                guncelle_atladi_o,   // Cozulen yon.
    output logic [`DAL_PS_W-1:0] guncelle_ps_o,      // Guncellenecek PS.
    output logic                dallanma_hata_o,     // Yanlis ongoru.
    output logic [`DAL_PS_W-1:0] duzeltme_ps_o       // Dogru sonraki PS.
);

    // ----------------------------------------
    // Yon cozumu
    // ----------------------------------------
    logic                 atladi;      // Cozulen yon.
    logic                 tur_gecerli; // 6 ve 7 disinda.
    logic [`DAL_PS_W-1:0] hedef_ps;    // Atlama hedefi.
    logic [`DAL_PS_W-1:0] sirali_ps;   // Bir sonraki buyruk.

    always_comb begin
        case (dal_buy_turu_i)
            DAL_BEQ:            atladi = esit_mi_i;
            DAL_BNE:            atladi = !esit_mi_i;
            DAL_BLT, DAL_BLTU:  atladi = !buyuk_mu_i && !esit_mi_i; // Kucuk kesin.
            DAL_BGE, DAL_BGEU:  atladi = buyuk_mu_i || esit_mi_i;   // Buyuk veya esit.
            default:            atladi = 1'b0;                       // Gecersiz tur.
        endcase
    end

    assign tur_gecerli = dal_turu_gecerli_mi(dal_buy_turu_i);

    // Hedef ve sirali adresler.
    assign hedef_ps  = dallanma_ps_i + anlik_i;
    assign sirali_ps = dallanma_ps_i + `DAL_PS_W'(`DAL_BUYRUK_BAYT);

    // ----------------------------------------
    // Cikis yazmaclari
    // ----------------------------------------
    logic                 gecerli_q;  // Guncelleme gecerli.
    logic                 atladi_q;   // Kayitli yon.
    logic                 hata_q;     // Kayitli hata.
    logic [`DAL_PS_W-1:0] ps_q;       // Kayitli dallanma PS.
    logic [`DAL_PS_W-1:0] duzeltme_q; // Kayitli duzeltme PS.

    // Kontrol bitleri.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            gecerli_q <= 1'b0;
            hata_q    <= 1'b0;
        end else begin
            gecerli_q <= blok_aktif_i && tur_gecerli;
            hata_q    <= blok_aktif_i && tur_gecerli && (dallanma_ongorusu_i != atladi);
        end
    end

    // Veri yazmaclari, gecerli ile birlikte okunur.
    always_ff @(posedge clk_i) begin
        atladi_q   <= atladi;
        ps_q       <= dallanma_ps_i;
        duzeltme_q <= atladi ? hedef_ps : sirali_ps;
    end

    assign guncelle_gecerli_o = gecerli_q;
    assign guncelle_atladi_o  = atladi_q;
    assign guncelle_ps_o      = ps_q;
    assign dallanma_hata_o    = hata_q;
    assign duzeltme_ps_o      = duzeltme_q;

endmodule

`default_nettype wire

// ==== src/dallanma_ongorucu.sv ====
`timescale 1ns/1ps
`include "dallanma_config.svh"
`default_nettype none

module dallanma_ongorucu
    import ongoru_pkg::*;
#(
    parameter sayac_e BASLANGIC_SAYAC = ZAYIF_ATLAMAZ // Sifirlamada tum girisler.
) (
    input  wire                 clk_i,              // Saat.
    input  wire                 rst_i,              // Senkron sifirlama.
    input  wire [`DAL_PS_W-1:0] tahmin_ps_i,        // Getir asamasi PS.
    output logic                tahmin_o,           // 1 ise atlar.
    input  wire                 guncelle_gecerli_i, // Guncelleme darbesi.
    input  wire                 guncelle_atladi_i,  // Cozulen yon.
    input  wire [`DAL_PS_W-1:0] guncelle_ps_i       // Guncellenecek PS.
);

    localparam int IDX_W    = `DAL_BHT_IDX_W;    // Indeks genisligi.
    localparam int IDX_LSB  = `DAL_BHT_IDX_LSB;  // Bayt ofseti atlanir.
    localparam int DERINLIK = `DAL_BHT_DERINLIK; // 64 giris.

    // ----------------------------------------
    // Sayac tablosu
    // ----------------------------------------
    sayac_e tablo [0:DERINLIK-1]; // Iki bitlik sayaclar.

    logic [IDX_W-1:0] okuma_idx;  // Getir PS'inden.
    logic [IDX_W-1:0] yazma_idx;  // Guncelleme PS'inden.
    sayac_e           eski_sayac; // Guncellenen girisin degeri.
    sayac_e           yeni_sayac; // Doyumlu sonraki deger.

    assign okuma_idx = tahmin_ps_i[IDX_LSB +: IDX_W];
    assign yazma_idx = guncelle_ps_i[IDX_LSB +: IDX_W];

    // Ayni cevrim bakisi.
    assign tahmin_o = sayac_atlar_mi(tablo[okuma_idx]);

    assign eski_sayac = tablo[yazma_idx];

    // ----------------------------------------
    // Doyumlu sayma
    // ----------------------------------------
    always_comb begin
        yeni_sayac = eski_sayac;
        if (guncelle_atladi_i) begin
            case (eski_sayac)
                GUCLU_ATLAMAZ: yeni_sayac = ZAYIF_ATLAMAZ;
                ZAYIF_ATLAMAZ: yeni_sayac = ZAYIF_ATLAR;
                ZAYIF_ATLAR:   yeni_sayac = GUCLU_ATLAR;
                default:       yeni_sayac = GUCLU_ATLAR; // Ustte doyar.
            endcase
        end else begin
            case (eski_sayac)
                GUCLU_ATLAR:   yeni_sayac = ZAYIF_ATLAR;
                ZAYIF_ATLAR:   yeni_sayac = ZAYIF_ATLAMAZ;
                ZAYIF_ATLAMAZ: yeni_sayac = GUCLU_ATLAMAZ;
                default:       yeni_sayac = GUCLU_ATLAMAZ; // Altta doyar.
            endcase
        end
    end

    // Tek cevrimde tum tablo temizlenir.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < DERINLIK; i++) begin
                tablo[i] <= BASLANGIC_SAYAC;
            end
        end else if (guncelle_gecerli_i) begin
            tablo[yazma_idx] <= yeni_sayac; // Sonraki cevrimde gorunur.
        end
    end

endmodule

`default_nettype wire

// ==== src/dallanma_alt_sistemi.sv ====
`timescale 1ns/1ps
`include "dallanma_config.svh"
`default_nettype none

module dallanma_alt_sistemi
    import dal_turu_pkg::*;
    import ongoru_pkg::*;
(
    input  wire                  clk_i,               // Saat.
    input  wire                  rst_i,               // Senkron sifirlama.
    input  wire  [`DAL_PS_W-1:0] tahmin_ps_i,         // Getir PS.
    output logic                 tahmin_o,            // Getir ongorusu.
    input  wire                  blok_aktif_i,        // Dallanma var.
    input  wire  [`DAL_PS_W-1:0] dallanma_ps_i,       // Dallanma PS.
    input  wire  [`DAL_PS_W-1:0] anlik_i,             // Anlik deger.
    input  wire  [`DAL_PS_W-1:0] kaynak1_i,           // rs1 degeri.
    input  wire  [`DAL_PS_W-1:0] kaynak2_i,           // rs2 degeri.
    input  wire dal_turu_e       dal_buy_turu_i,      // Dallanma turu.
    input  wire                  dallanma_ongorusu_i, // Tasinan ongoru.
    output logic                 dallanma_hata_o,     // Yanlis ongoru.
    output logic [`DAL_PS_W-1:0] duzeltme_ps_o        // Dogru sonraki PS.
);

    // ----------------------------------------
    // Ic baglantilar
    // ----------------------------------------
    logic                 esit_mi;          // Esitlik bayragi.
    logic                 buyuk_mu;         // Buyukluk bayragi.
    logic                 guncelle_gecerli; // Birimden ongorucuye.
    logic                 guncelle_atladi;
    logic [`DAL_PS_W-1:0] guncelle_ps;

    karsilastirici karsilastirici_inst (
        .kaynak1_i  (kaynak1_i),
        .kaynak2_i  (kaynak2_i),
        .dal_turu_i (dal_buy_turu_i),
        .esit_mi_o  (esit_mi),
        .buyuk_mu_o (buyuk_mu)
    );

    dallanma_birimi dallanma_birimi_inst (
        .clk_i               (clk_i),
        .rst_i               (rst_i),
        .blok_aktif_i        (blok_aktif_i),
        .dallanma_ps_i       (dallanma_ps_i),
        .anlik_i             (anlik_i),
        .dal_buy_turu_i      (dal_buy_turu_i),
        .dallanma_ongorusu_i (dallanma_ongorusu_i),
        .esit_mi_i           (esit_mi),
        .buyuk_mu_i          (buyuk_mu),
        .guncelle_gecerli_o  (guncelle_gecerli),
        .guncelle_atladi_o   (guncelle_atladi),
        .guncelle_ps_o       (guncelle_ps),
        .dallanma_hata_o     (dallanma_hata_o),
        .duzeltme_ps_o       (duzeltme_ps_o)
    );

    // Sifirlama sonrasi zayif atlamaz.
    dallanma_ongorucu #(
        .BASLANGIC_SAYAC (SAYAC_SIFIR)
    ) dallanma_ongorucu_inst (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .tahmin_ps_i        (tahmin_ps_i),
        .tahmin_o           (tahmin_o),
        .guncelle_gecerli_i (guncelle_gecerli),
        .guncelle_atladi_i  (guncelle_atladi),
        .guncelle_ps_i      (guncelle_ps)
    );

endmodule

`default_nettype wire

// ==== dv/dallanma_tb.sv ====
`timescale 1ns/1ps
`include "dallanma_config.svh"
`default_nettype none

module dallanma_tb
    import dal_turu_pkg::*;
();

    localparam int PS_W           = `DAL_PS_W;
    localparam int IDX_W          = `DAL_BHT_IDX_W;
    localparam int IDX_LSB        = `DAL_BHT_IDX_LSB;
    localparam int STREAM_LEN     = 40;   // Back-to-back branches.
    localparam int TIMEOUT_CYCLES = 2000; // Tests take a few hundred cycles.

    // ----------------------------------------
    // DUT signals
    // ----------------------------------------
    logic            clk;
    logic            rst;
    logic [PS_W-1:0] tahmin_ps;
    logic            tahmin;
    logic            blok_aktif;
    logic [PS_W-1:0] dallanma_ps;
    logic [PS_W-1:0] anlik;
    logic [PS_W-1:0] kaynak1;
    logic [PS_W-1:0] kaynak2;
    dal_turu_e       dal_buy_turu;
    logic            ongoru;
    logic            hata;
    logic [PS_W-1:0] duzeltme_ps;

    int          errors;
    int          checks;
    int          cycle_count;
    logic [31:0] rng_state;
    logic [1:0]  shadow [0:(1<<IDX_W)-1]; // Reference counters where 0 is strongly not taken.

    dallanma_alt_sistemi dallanma_alt_sistemi_inst (
        .clk_i               (clk),
        .rst_i               (rst),
        .tahmin_ps_i         (tahmin_ps),
        .tahmin_o            (tahmin),
        .blok_aktif_i        (blok_aktif),
        .dallanma_ps_i       (dallanma_ps),
        .anlik_i             (anlik),
        .kaynak1_i           (kaynak1),
        .kaynak2_i           (kaynak2),
        .dal_buy_turu_i      (dal_buy_turu),
        .dallanma_ongorusu_i (ongoru),
        .dallanma_hata_o     (hata),
        .duzeltme_ps_o       (duzeltme_ps)
    );

    always #2 clk = ~clk; // 4 ns period.

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish.", cycle_count);
            $display("Regression failed");
            $finish;
        end
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223; // LCG step.
        return rng_state;
    endfunction

    function automatic logic model_taken(input logic [2:0] tur, input logic [31:0] a,
                                         input logic [31:0] b);
        case (tur)
            DAL_BEQ:  return a == b;
            DAL_BNE:  return a != b;
            DAL_BLT:  return $signed(a) < $signed(b);
            DAL_BGE:  return $signed(a) >= $signed(b);
            DAL_BLTU: return a < b;
            DAL_BGEU: return a >= b;
            default:  return 1'b0; // Codes 6 and 7.
        endcase
    endfunction

    function automatic logic shadow_prediction(input logic [31:0] pc);
        return shadow[pc[IDX_LSB +: IDX_W]][1]; // Upper half predicts taken.
    endfunction

    task automatic update_shadow(input logic [31:0] pc, input logic taken);
        logic [IDX_W-1:0] idx;
        idx = pc[IDX_LSB +: IDX_W];
        if (taken && shadow[idx] != 2'd3) begin
            shadow[idx] = shadow[idx] + 2'd1;
        end else if (!taken && shadow[idx] != 2'd0) begin
            shadow[idx] = shadow[idx] - 2'd1;
        end
    endtask

    task automatic report_bit(input string name, input logic expected, input logic actual);
        errors++;
        $display("error at %0.1f ns: %s expected %0b, got %0b", $realtime, name, expected,
                 actual);
    endtask

    task automatic report_word(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        errors++;
        $display("error at %0.1f ns: %s expected %08h, got %08h", $realtime, name, expected,
                 actual);
    endtask

    // ----------------------------------------
    // Drive and check helpers
    // ----------------------------------------
    task automatic drive_branch(input logic [2:0] tur, input logic [31:0] pc,
                                input logic [31:0] imm, input logic [31:0] a,
                                input logic [31:0] b, input logic pred);
        blok_aktif   <= 1'b1;
        dallanma_ps  <= pc;
        anlik        <= imm;
        kaynak1      <= a;
        kaynak2      <= b;
        dal_buy_turu <= dal_turu_e'(tur);
        ongoru       <= pred;
    endtask

    // Called in the result cycle of the branch.
    task automatic check_result(input logic [2:0] tur, input logic [31:0] pc,
                                input logic [31:0] imm, input logic [31:0] a,
                                input logic [31:0] b, input logic pred);
        logic        taken;
        logic        valid;
        logic        exp_hata;
        logic [31:0] exp_ps;
        taken    = model_taken(tur, a, b);
        valid    = (tur <= 3'd5);
        exp_hata = valid && (pred != taken);
        exp_ps   = taken ? pc + imm : pc + 32'd4;
        checks++;
        if (hata !== exp_hata) report_bit("dallanma_hata_o", exp_hata, hata);
        if (valid && (duzeltme_ps !== exp_ps)) report_word("duzeltme_ps_o", exp_ps, duzeltme_ps);
        if (valid) update_shadow(pc, taken); // Invalid types train nothing.
    endtask

    task automatic apply_branch(input logic [2:0] tur, input logic [31:0] pc,
                                input logic [31:0] imm, input logic [31:0] a,
                                input logic [31:0] b, input logic pred);
        @(posedge clk);
        drive_branch(tur, pc, imm, a, b, pred);
        @(posedge clk);
        blok_aktif <= 1'b0;
        @(negedge clk);
        check_result(tur, pc, imm, a, b, pred);
    endtask

    task automatic probe_prediction(input logic [31:0] pc, input logic expected);
        @(posedge clk);
        tahmin_ps <= pc;
        @(negedge clk); // Combinational lookup settled.
        checks++;
        if (tahmin !== expected) report_bit("tahmin_o", expected, tahmin);
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task automatic check_reset_state();
        @(negedge clk);
        checks++;
        if (hata !== 1'b0) report_bit("dallanma_hata_o", 1'b0, hata);
        probe_prediction(32'h0000_0000, 1'b0); // Weakly not taken everywhere.
        probe_prediction(32'h0000_00FC, 1'b0);
        probe_prediction(32'h1000_0040, 1'b0);
        probe_prediction(32'hFFFF_FFFC, 1'b0);
    endtask

    task automatic train_predictor();
        logic [31:0] pc_train;
        logic [31:0] pc_other;
        pc_train = 32'h0000_2040; // Index 16.
        pc_other = 32'h0000_2044; // Index 17.
        apply_branch(DAL_BEQ, pc_train, 32'h0000_0010, 32'd7, 32'd7, 1'b0);
        probe_prediction(pc_train, 1'b1); // Two cycles after presentation.
        repeat (2) apply_branch(DAL_BEQ, pc_train, 32'h0000_0010, 32'd7, 32'd7, 1'b1);
        apply_branch(DAL_BEQ, pc_train, 32'h0000_0010, 32'd7, 32'd8, 1'b1); // Not taken.
        probe_prediction(pc_train, 1'b1); // Saturated counter holds.
        probe_prediction(pc_other, 1'b0);
    endtask

    task automatic check_invalid_types();
        logic [31:0] pc_inv;
        pc_inv = 32'h0000_30A8;
        apply_branch(DAL_BEQ, pc_inv, 32'h0000_0040, 32'd3, 32'd3, 1'b1); // Weakly taken.
        apply_branch(3'd6, pc_inv, 32'h0000_0040, 32'd3, 32'd3, 1'b1);
        apply_branch(3'd7, pc_inv, 32'h0000_0040, 32'd9, 32'd3, 1'b0);
        probe_prediction(pc_inv, shadow_prediction(pc_inv)); // Still taken.
    endtask

    task automatic check_branch_types();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        for (int t = 0; t < 6; t++) begin
            for (int c = 0; c < 7; c++) begin
                r = next_random();
                case (c)
                    4: begin
                        a = next_random();
                        b = a;
                    end
                    5: begin // Signed versus unsigned.
                        a = 32'h8000_0000;
                        b = 32'd1;
                    end
                    6: begin
                        a = 32'd1;
                        b = 32'h8000_0000;
                    end
                    default: begin
                        a = next_random();
                        b = next_random();
                    end
                endcase
                apply_branch(3'(t), next_random() & 32'hFFFF_FFFC, next_random() & 32'hFFFF_FFFE,
                             a, b, r[23]);
            end
        end
    endtask

    task automatic run_back_to_back();
        logic [2:0]  tur;
        logic [31:0] pc;
        logic [31:0] imm;
        logic [31:0] a;
        logic [31:0] b;
        logic        pred;
        logic [31:0] r;
        logic [2:0]  p_tur;
        logic [31:0] p_pc;
        logic [31:0] p_imm;
        logic [31:0] p_a;
        logic [31:0] p_b;
        logic        p_pred;
        for (int i = 0; i < STREAM_LEN; i++) begin
            r    = next_random();
            tur  = r[18:16];                          // Invalid codes included.
            pred = r[24];
            pc   = next_random() & 32'hFFFF_001C;     // Eight indexes with aliased upper bits.
            imm  = next_random() & 32'hFFFF_FFFE;
            a    = next_random();
            b    = (r[27:26] == 2'd0) ? a : next_random();
            @(posedge clk);
            drive_branch(tur, pc, imm, a, b, pred);
            @(negedge clk);
            if (i > 0) check_result(p_tur, p_pc, p_imm, p_a, p_b, p_pred); // Previous branch.
            p_tur  = tur;
            p_pc   = pc;
            p_imm  = imm;
            p_a    = a;
            p_b    = b;
            p_pred = pred;
        end
        @(posedge clk);
        blok_aktif <= 1'b0;
        @(negedge clk);
        check_result(p_tur, p_pc, p_imm, p_a, p_b, p_pred);
        for (int k = 0; k < (1 << IDX_W); k++) begin
            probe_prediction(32'(k) << IDX_LSB, shadow_prediction(32'(k) << IDX_LSB));
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        tahmin_ps    = '0;
        blok_aktif   = 1'b0;
        dallanma_ps  = '0;
        anlik        = '0;
        kaynak1      = '0;
        kaynak2      = '0;
        dal_buy_turu = DAL_BEQ;
        ongoru       = 1'b0;
        errors       = 0;
        checks       = 0;
        cycle_count  = 0;
        rng_state    = 32'h8da5;
        for (int i = 0; i < (1 << IDX_W); i++) begin
            shadow[i] = 2'd1; // Reset state of the table.
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        check_reset_state();
        train_predictor();
        check_invalid_types();
        check_branch_types();
        run_back_to_back();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+src
src/dal_turu_pkg.sv
src/ongoru_pkg.sv
src/karsilastirici.sv
src/dallanma_birimi.sv
src/dallanma_ongorucu.sv
src/dallanma_alt_sistemi.sv
dv/dallanma_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the branch subsystem testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
    -f files.f --top-module dallanma_tb -o dallanma_sim

./obj_dir/dallanma_sim > sim.log 2>&1
cat sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
exit 0
